//--- cgra_pkg.sv
// CGRA shell package
// Shared widths, vector types, PE opcodes, CSR field positions and
// the run state encoding for the 1x4 stream accelerator
package cgra_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------
  localparam int unsigned NumLanes        = 4;
  localparam int unsigned NarrowDataWidth = 64;
  localparam int unsigned NumRwCsr        = 2;
  localparam int unsigned NumRoCsr        = 4;
  localparam int unsigned FifoDepth       = 4;
  localparam int unsigned CsrWidth        = 32;
  localparam int unsigned BeatCntWidth    = 16;
  localparam int unsigned PeCfgWidth      = 8;

  typedef logic [NarrowDataWidth-1:0] lane_data_t;
  typedef logic [CsrWidth-1:0]        csr_word_t;
  typedef logic [2:0]                 pe_op_t;
  typedef logic [1:0]                 lane_sel_t;
  typedef logic [BeatCntWidth-1:0]    beat_cnt_t;
  typedef logic [PeCfgWidth-1:0]      pe_cfg_t;

  // --------------------------------------------------
  // PE opcodes
  // --------------------------------------------------
  localparam pe_op_t OpAdd   = 3'd0;
  localparam pe_op_t OpSub   = 3'd1;
  localparam pe_op_t OpMul   = 3'd2;
  localparam pe_op_t OpAnd   = 3'd3;
  localparam pe_op_t OpOr    = 3'd4;
  localparam pe_op_t OpXor   = 3'd5;
  localparam pe_op_t OpPassA = 3'd6;
  localparam pe_op_t OpMaxU  = 3'd7;

  // Field layout of one PE byte in CSR word 0
  localparam int unsigned CfgOpLsb   = 0;
  localparam int unsigned CfgSrcALsb = 3;
  localparam int unsigned CfgSrcBLsb = 5;
  localparam int unsigned CfgAccBit  = 7;

  // CSR word 1 holds the beat count in the low half
  localparam int unsigned StartBit = 31;

  typedef enum logic [1:0] {
    RunIdle,
    RunActive,
    RunDrain
  } run_state_e;

endpackage

//--- cgra_cfg_if.sv
// CGRA configuration interface
// Carries the PE configuration and run control from the CSR block to
// the PE array, and beat and drain status back
`timescale 1ns/1ps

interface cgra_cfg_if;
  import cgra_pkg::*;

  // Towards the array
  pe_cfg_t pe_cfg [NumLanes];
  logic    clear;
  logic    beats_left_nz;

  // Back to the CSR block
  logic    beat_fire;
  logic    all_empty;
  logic    stall;

  modport csr (
    output pe_cfg, clear, beats_left_nz,
    input  beat_fire, all_empty, stall
  );

  modport array (
    input  pe_cfg, clear, beats_left_nz,
    output beat_fire, all_empty, stall
  );

endinterface

//--- cgra_pe.sv
// CGRA processing element
// Picks two operands from the joined lanes, applies the configured
// operation and registers the plain or accumulated result
`timescale 1ns/1ps

module cgra_pe (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  cgra_pkg::lane_data_t lanes_i [cgra_pkg::NumLanes],
  input  cgra_pkg::pe_cfg_t    cfg_i,
  input  logic                 clear_i,
  input  logic                 fire_i,
  output cgra_pkg::lane_data_t result_o,
  output logic                 result_valid_o
);
  import cgra_pkg::*;

  pe_op_t     op;
  lane_sel_t  src_a;
  lane_sel_t  src_b;
  logic       acc_en;
  lane_data_t op_a;
  lane_data_t op_b;
  lane_data_t alu;
  lane_data_t acc_q;
  lane_data_t acc_sum;

  assign op     = cfg_i[CfgOpLsb +: $bits(pe_op_t)];
  assign src_a  = cfg_i[CfgSrcALsb +: $bits(lane_sel_t)];
  assign src_b  = cfg_i[CfgSrcBLsb +: $bits(lane_sel_t)];
  assign acc_en = cfg_i[CfgAccBit];
  assign op_a   = lanes_i[src_a];
  assign op_b   = lanes_i[src_b];

  always_comb begin
    case (op)
      OpAdd:   alu = op_a + op_b;
      OpSub:   alu = op_a - op_b;
      OpMul:   alu = op_a * op_b;
      OpAnd:   alu = op_a & op_b;
      OpOr:    alu = op_a | op_b;
      OpXor:   alu = op_a ^ op_b;
      OpPassA: alu = op_a;
      default: alu = (op_a > op_b) ? op_a : op_b;
    endcase
  end

  // A beat in the clear cycle starts from zero
  assign acc_sum = (clear_i ? '0 : acc_q) + alu;

  always_ff @(posedge clk_i) begin
    if (fire_i && acc_en) begin
      acc_q <= acc_sum;
    end else if (clear_i) begin
      acc_q <= '0;
    end
    if (fire_i) begin
      result_o <= acc_en ? acc_sum : alu;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= fire_i;
    end
  end

endmodule

//--- cgra_out_fifo.sv
// CGRA output FIFO
// Circular buffer per output lane with valid/ready on the read side
// and a flag for two or more free entries on the write side
`timescale 1ns/1ps

module cgra_out_fifo #(
  parameter int unsigned Depth = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 push_i,
  input  cgra_pkg::lane_data_t data_i,
  output logic                 space_o,
  output cgra_pkg::lane_data_t data_o,
  output logic                 valid_o,
  input  logic                 ready_i
);
  import cgra_pkg::*;

  localparam int unsigned PtrWidth = $clog2(Depth);
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  lane_data_t          mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                pop;

  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign pop     = valid_o && ready_i;
  // Room for the word in the PE register plus one more beat
  assign space_o = (count_q <= CntWidth'(Depth - 2));

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap on their own since Depth is a power of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + CntWidth'(push_i) - CntWidth'(pop);
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> count_q != CntWidth'(Depth))
    else $error("push into a full output FIFO");

endmodule

//--- cgra_array.sv
// CGRA PE array
// Joins one word from every input lane per beat, runs four PEs in
// lockstep and buffers each result lane in its own output FIFO
`timescale 1ns/1ps

module cgra_array (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  cgra_pkg::lane_data_t          in_data_i [cgra_pkg::NumLanes],
  input  logic [cgra_pkg::NumLanes-1:0] in_valid_i,
  output logic [cgra_pkg::NumLanes-1:0] in_ready_o,
  output cgra_pkg::lane_data_t          out_data_o [cgra_pkg::NumLanes],
  output logic [cgra_pkg::NumLanes-1:0] out_valid_o,
  input  logic [cgra_pkg::NumLanes-1:0] out_ready_i,
  output logic [cgra_pkg::NumLanes-1:0] out_fire_o,
  cgra_cfg_if.array                     cfg
);
  import cgra_pkg::*;

  lane_data_t          pe_result [NumLanes];
  logic [NumLanes-1:0] pe_valid;
  logic [NumLanes-1:0] space;
  logic                all_space;
  logic                join_ready;

  // --------------------------------------------------
  // Lockstep join
  // --------------------------------------------------
  assign all_space  = &space;
  assign join_ready = cfg.beats_left_nz && all_space;
  // Readies rise together and never wait on the valids
  assign in_ready_o = {NumLanes{join_ready}};

  assign cfg.beat_fire = join_ready && (&in_valid_i);
  assign cfg.stall     = cfg.beats_left_nz && (&in_valid_i) && !all_space;
  assign cfg.all_empty = !(|out_valid_o) && !(|pe_valid);

  assign out_fire_o = out_valid_o & out_ready_i;

  // --------------------------------------------------
  // PEs and output FIFOs
  // --------------------------------------------------
  for (genvar g = 0; g < NumLanes; g++) begin : gen_lane
    cgra_pe pe_inst (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .lanes_i        (in_data_i),
      .cfg_i          (cfg.pe_cfg[g]),
      .clear_i        (cfg.clear),
      .fire_i         (cfg.beat_fire),
      .result_o       (pe_result[g]),
      .result_valid_o (pe_valid[g])
    );

    cgra_out_fifo #(
      .Depth (FifoDepth)
    ) fifo_inst (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (pe_valid[g]),
      .data_i  (pe_result[g]),
      .space_o (space[g]),
      .data_o  (out_data_o[g]),
      .valid_o (out_valid_o[g]),
      .ready_i (out_ready_i[g])
    );
  end

endmodule

//--- cgra_csr.sv
// CGRA CSR block
// Accepts the packed two-word write, holds the PE configuration,
// sequences a run of the programmed beat count and builds status
`timescale 1ns/1ps

module cgra_csr (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  cgra_pkg::csr_word_t [cgra_pkg::NumRwCsr-1:0]  csr_set_i,
  input  logic                                          csr_set_valid_i,
  output logic                                          csr_set_ready_o,
  output cgra_pkg::csr_word_t [cgra_pkg::NumRoCsr-1:0]  csr_ro_o,
  input  logic [cgra_pkg::NumLanes-1:0]                 out_fire_i,
  cgra_cfg_if.csr                                       cfg
);
  import cgra_pkg::*;

  run_state_e state_q;
  pe_cfg_t    pe_cfg_q [NumLanes];
  beat_cnt_t  beats_left_q;
  beat_cnt_t  beats_done_q;
  beat_cnt_t  run_len;
  csr_word_t  stall_cnt_q;
  csr_word_t  out_cnt_q;
  logic [2:0] out_fire_cnt;
  logic       ready_en_q;
  logic       clear_q;
  logic       done_q;
  logic       busy;
  logic       accept;

  assign busy            = (state_q != RunIdle);
  assign csr_set_ready_o = ready_en_q && !busy;
  assign accept          = csr_set_valid_i && csr_set_ready_o;
  assign run_len         = csr_set_i[1][BeatCntWidth-1:0];

  assign cfg.pe_cfg        = pe_cfg_q;
  assign cfg.clear         = clear_q;
  assign cfg.beats_left_nz = (state_q == RunActive) && (beats_left_q != '0);

  // --------------------------------------------------
  // Configuration and run sequencing
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_en_q <= 1'b0;
      for (int i = 0; i < NumLanes; i++) begin
        pe_cfg_q[i] <= '0;
      end
    end else begin
      ready_en_q <= 1'b1;
      if (accept) begin
        for (int i = 0; i < NumLanes; i++) begin
          pe_cfg_q[i] <= csr_set_i[0][i*PeCfgWidth +: PeCfgWidth];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= RunIdle;
      beats_left_q <= '0;
      beats_done_q <= '0;
      stall_cnt_q  <= '0;
      clear_q      <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      clear_q <= 1'b0;
      case (state_q)
        RunIdle: begin
          if (accept && csr_set_i[1][StartBit]) begin
            beats_left_q <= run_len;
            beats_done_q <= '0;
            stall_cnt_q  <= '0;
            // An empty run finishes on the spot
            done_q       <= (run_len == '0);
            if (run_len != '0) begin
              state_q <= RunActive;
              clear_q <= 1'b1;
            end
          end
        end
        RunActive: begin
          if (cfg.beat_fire) begin
            beats_left_q <= beats_left_q - 1'b1;
            beats_done_q <= beats_done_q + 1'b1;
            if (beats_left_q == beat_cnt_t'(1)) begin
              state_q <= RunDrain;
            end
          end
          if (cfg.stall) begin
            stall_cnt_q <= stall_cnt_q + 1'b1;
          end
        end
        RunDrain: begin
          if (cfg.all_empty) begin
            state_q <= RunIdle;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= RunIdle;
      endcase
    end
  end

  // --------------------------------------------------
  // Output handshake total
  // --------------------------------------------------
  always_comb begin
    out_fire_cnt = '0;
    for (int i = 0; i < NumLanes; i++) begin
      out_fire_cnt = out_fire_cnt + 3'(out_fire_i[i]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_cnt_q <= '0;
    end else begin
      out_cnt_q <= out_cnt_q + CsrWidth'(out_fire_cnt);
    end
  end

  assign csr_ro_o[0] = {30'b0, done_q, busy};
  assign csr_ro_o[1] = CsrWidth'(beats_done_q);
  assign csr_ro_o[2] = stall_cnt_q;
  assign csr_ro_o[3] = out_cnt_q;

  a_no_fire_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg.beat_fire |-> state_q != RunIdle)
    else $error("beat joined while idle");

  a_no_write_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accept |-> cfg.all_empty && !cfg.beat_fire)
    else $error("CSR write accepted during a run");

endmodule

//--- cgra_shell_wrapper.sv
// CGRA shell wrapper
// Top level of the stream accelerator: flattens the four input and
// four output lanes to plain ports and joins CSR block and PE array
`timescale 1ns/1ps

module cgra_shell_wrapper (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,

  // Streamer to accelerator
  input  cgra_pkg::lane_data_t                          stream2acc_0_data_i,
  input  logic                                          stream2acc_0_valid_i,
  output logic                                          stream2acc_0_ready_o,
  input  cgra_pkg::lane_data_t                          stream2acc_1_data_i,
  input  logic                                          stream2acc_1_valid_i,
  output logic                                          stream2acc_1_ready_o,
  input  cgra_pkg::lane_data_t                          stream2acc_2_data_i,
  input  logic                                          stream2acc_2_valid_i,
  output logic                                          stream2acc_2_ready_o,
  input  cgra_pkg::lane_data_t                          stream2acc_3_data_i,
  input  logic                                          stream2acc_3_valid_i,
  output logic                                          stream2acc_3_ready_o,

  // Accelerator to streamer
  output cgra_pkg::lane_data_t                          acc2stream_0_data_o,
  output logic                                          acc2stream_0_valid_o,
  input  logic                                          acc2stream_0_ready_i,
  output cgra_pkg::lane_data_t                          acc2stream_1_data_o,
  output logic                                          acc2stream_1_valid_o,
  input  logic                                          acc2stream_1_ready_i,
  output cgra_pkg::lane_data_t                          acc2stream_2_data_o,
  output logic                                          acc2stream_2_valid_o,
  input  logic                                          acc2stream_2_ready_i,
  output cgra_pkg::lane_data_t                          acc2stream_3_data_o,
  output logic                                          acc2stream_3_valid_o,
  input  logic                                          acc2stream_3_ready_i,

  // Packed CSR port
  input  cgra_pkg::csr_word_t [cgra_pkg::NumRwCsr-1:0]  csr_reg_set_i,
  input  logic                                          csr_reg_set_valid_i,
  output logic                                          csr_reg_set_ready_o,
  output cgra_pkg::csr_word_t [cgra_pkg::NumRoCsr-1:0]  csr_reg_ro_set_o
);
  import cgra_pkg::*;

  lane_data_t          in_data  [NumLanes];
  lane_data_t          out_data [NumLanes];
  logic [NumLanes-1:0] in_valid;
  logic [NumLanes-1:0] in_ready;
  logic [NumLanes-1:0] out_valid;
  logic [NumLanes-1:0] out_ready;
  logic [NumLanes-1:0] out_fire;

  // --------------------------------------------------
  // Lane packing
  // --------------------------------------------------
  assign in_data  = '{stream2acc_0_data_i, stream2acc_1_data_i,
                      stream2acc_2_data_i, stream2acc_3_data_i};
  assign in_valid = {stream2acc_3_valid_i, stream2acc_2_valid_i,
                     stream2acc_1_valid_i, stream2acc_0_valid_i};
  assign {stream2acc_3_ready_o, stream2acc_2_ready_o,
          stream2acc_1_ready_o, stream2acc_0_ready_o} = in_ready;

  assign acc2stream_0_data_o = out_data[0];
  assign acc2stream_1_data_o = out_data[1];
  assign acc2stream_2_data_o = out_data[2];
  assign acc2stream_3_data_o = out_data[3];
  assign {acc2stream_3_valid_o, acc2stream_2_valid_o,
          acc2stream_1_valid_o, acc2stream_0_valid_o} = out_valid;
  assign out_ready = {acc2stream_3_ready_i, acc2stream_2_ready_i,
                      acc2stream_1_ready_i, acc2stream_0_ready_i};

  // --------------------------------------------------
  // CSR block and array
  // --------------------------------------------------
  cgra_cfg_if cfg_if ();

  cgra_csr csr_inst (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .csr_set_i       (csr_reg_set_i),
    .csr_set_valid_i (csr_reg_set_valid_i),
    .csr_set_ready_o (csr_reg_set_ready_o),
    .csr_ro_o        (csr_reg_ro_set_o),
    .out_fire_i      (out_fire),
    .cfg             (cfg_if.csr)
  );

  cgra_array array_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_data_i   (in_data),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .out_data_o  (out_data),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .out_fire_o  (out_fire),
    .cfg         (cfg_if.array)
  );

endmodule

//--- tb_cgra_shell.sv
// Testbench for the CGRA stream accelerator shell
// Plays the streamer on four input and four output lanes, programs
// runs through the CSR port and checks every result word in order
`timescale 1ns/1ps

module tb_cgra_shell;
  import cgra_pkg::*;

  localparam int OpBeats     = 12;
  localparam int AccBeats    = 16;
  localparam int StressBeats = 64;
  localparam int TotalBeats  = 8 * OpBeats + 2 * AccBeats + StressBeats;
  localparam int CycleLimit  = 40 * TotalBeats + 500;

  logic                         clk;
  logic                         rst_n;
  lane_data_t                   in_data  [NumLanes];
  lane_data_t                   out_data [NumLanes];
  logic [NumLanes-1:0]          in_valid;
  logic [NumLanes-1:0]          in_ready;
  logic [NumLanes-1:0]          out_valid;
  logic [NumLanes-1:0]          out_ready;
  csr_word_t [NumRwCsr-1:0]     csr_set;
  logic                         csr_valid;
  logic                         csr_ready;
  csr_word_t [NumRoCsr-1:0]     csr_ro;

  // Model state
  lane_data_t exp_q [NumLanes][$];
  lane_data_t acc_model [NumLanes];
  pe_cfg_t    cfg_model [NumLanes];
  logic [15:0] lfsr_stim;
  logic [15:0] lfsr_rdy;
  logic        stall_en;
  int          stall_model;
  int          delivered_total;
  int          cycles;
  int          checks;
  int          errors;

  cgra_shell_wrapper cgra_shell_wrapper_inst (
    .clk_i                (clk),
    .rst_n_i              (rst_n),
    .stream2acc_0_data_i  (in_data[0]),
    .stream2acc_0_valid_i (in_valid[0]),
    .stream2acc_0_ready_o (in_ready[0]),
    .stream2acc_1_data_i  (in_data[1]),
    .stream2acc_1_valid_i (in_valid[1]),
    .stream2acc_1_ready_o (in_ready[1]),
    .stream2acc_2_data_i  (in_data[2]),
    .stream2acc_2_valid_i (in_valid[2]),
    .stream2acc_2_ready_o (in_ready[2]),
    .stream2acc_3_data_i  (in_data[3]),
    .stream2acc_3_valid_i (in_valid[3]),
    .stream2acc_3_ready_o (in_ready[3]),
    .acc2stream_0_data_o  (out_data[0]),
    .acc2stream_0_valid_o (out_valid[0]),
    .acc2stream_0_ready_i (out_ready[0]),
    .acc2stream_1_data_o  (out_data[1]),
    .acc2stream_1_valid_o (out_valid[1]),
    .acc2stream_1_ready_i (out_ready[1]),
    .acc2stream_2_data_o  (out_data[2]),
    .acc2stream_2_valid_o (out_valid[2]),
    .acc2stream_2_ready_i (out_ready[2]),
    .acc2stream_3_data_o  (out_data[3]),
    .acc2stream_3_valid_o (out_valid[3]),
    .acc2stream_3_ready_i (out_ready[3]),
    .csr_reg_set_i        (csr_set),
    .csr_reg_set_valid_i  (csr_valid),
    .csr_reg_set_ready_o  (csr_ready),
    .csr_reg_ro_set_o     (csr_ro)
  );

  always #10 clk = ~clk;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(inout logic [15:0] st, input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      st = lfsr_next(st);
      v  = {v[62:0], st[0]};
    end
  endtask

  function automatic lane_data_t pe_alu(input pe_op_t op, input lane_data_t a,
                                        input lane_data_t b);
    case (op)
      OpAdd:   return a + b;
      OpSub:   return a - b;
      OpMul:   return a * b;
      OpAnd:   return a & b;
      OpOr:    return a | b;
      OpXor:   return a ^ b;
      OpPassA: return a;
      default: return (a > b) ? a : b;
    endcase
  endfunction

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Random selects; opcodes rotate per PE unless fully random
  task automatic build_cfg(input int op_base, input bit acc_in, input bit rand_all,
                           output csr_word_t w);
    logic [63:0] r;
    logic [63:0] o;
    w = '0;
    for (int i = 0; i < NumLanes; i++) begin
      take_bits(lfsr_stim, 4, r);
      take_bits(lfsr_stim, 4, o);
      if (rand_all) begin
        w[i*8 +: 8] = {o[3], r[3:2], r[1:0], o[2:0]};
      end else begin
        w[i*8 +: 8] = {acc_in, r[3:2], r[1:0], 3'((op_base + i) % 8)};
      end
    end
  endtask

  // Called and returns 2 ns after a rising edge
  task automatic run_case(input csr_word_t cfg_word, input int beats, input bit gaps);
    logic [63:0] r;
    csr_set[0] = cfg_word;
    csr_set[1] = (csr_word_t'(1) << StartBit) | csr_word_t'(beats);
    csr_valid  = 1'b1;
    do @(posedge clk); while (!csr_ready);
    for (int i = 0; i < NumLanes; i++) begin
      cfg_model[i] = cfg_word[i*8 +: 8];
      acc_model[i] = '0;
    end
    stall_model = 0;
    #2;
    csr_valid = 1'b0;
    if (beats != 0) check("CSR ready right after start", csr_ready, 1'b0);
    for (int b = 0; b < beats; b++) begin
      r = '0;
      if (gaps) take_bits(lfsr_stim, 2, r);
      if (r[1:0] != 0) begin
        in_valid = '0;
        repeat (r[1:0]) begin
          @(posedge clk);
          #2;
        end
      end
      for (int k = 0; k < NumLanes; k++) begin
        take_bits(lfsr_stim, 64, r);
        in_data[k] = r;
      end
      in_valid = '1;
      do @(posedge clk); while (!in_ready[0]);
      #2;
    end
    in_valid = '0;
    while (!csr_ro[0][1]) begin
      @(posedge clk);
      #2;
    end
    delivered_total += beats;
    check("status word 0 after run", csr_ro[0], 32'd2);
    check("beats accepted", csr_ro[1], beats);
    check("stall cycles", csr_ro[2], stall_model);
    check("output handshake total", csr_ro[3], 4 * delivered_total);
    check("output valids after run", out_valid, '0);
    for (int k = 0; k < NumLanes; k++) begin
      check("words still expected", exp_q[k].size(), 0);
    end
  endtask

  // --------------------------------------------------
  // Output ready driver, own LFSR state
  // --------------------------------------------------
  always @(posedge clk) begin : drive_ready
    logic [63:0] r;
    #2;
    for (int k = 0; k < NumLanes; k++) begin
      r = '1;
      if (stall_en) take_bits(lfsr_rdy, 2, r);
      out_ready[k] = (r[1:0] != 2'b00);
    end
  end

  // --------------------------------------------------
  // Reference model and compare
  // --------------------------------------------------
  always @(posedge clk) begin : compare
    lane_data_t alu;
    if (rst_n) begin
      if (csr_ro[0][0]) begin
        check("CSR ready while busy", csr_ready, 1'b0);
      end else begin
        check("input readies while idle", in_ready, '0);
      end
      check("input readies together", (in_ready == '0) || (in_ready == '1), 1'b1);
      // A pending beat held back by a full output lane
      if ((&in_valid) && !in_ready[0]) begin
        stall_model++;
      end
      if ((&in_valid) && in_ready[0]) begin
        for (int k = 0; k < NumLanes; k++) begin
          alu = pe_alu(cfg_model[k][2:0], in_data[cfg_model[k][4:3]],
                       in_data[cfg_model[k][6:5]]);
          if (cfg_model[k][7]) begin
            acc_model[k] = acc_model[k] + alu;
            exp_q[k].push_back(acc_model[k]);
          end else begin
            exp_q[k].push_back(alu);
          end
        end
      end
      for (int k = 0; k < NumLanes; k++) begin
        if (out_valid[k] && out_ready[k]) begin
          if (exp_q[k].size() == 0) begin
            errors++;
            $display("Error at %0t ns: lane %0d delivered a word with none expected", $time, k);
          end else begin
            check($sformatf("lane %0d result", k), out_data[k], exp_q[k].pop_front());
          end
        end
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("Test failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin : main
    csr_word_t w;
    clk = 1'b0;
    rst_n = 1'b0;
    in_valid = '0;
    out_ready = '1;
    csr_valid = 1'b0;
    csr_set = '0;
    for (int k = 0; k < NumLanes; k++) begin
      in_data[k] = '0;
      cfg_model[k] = '0;
      acc_model[k] = '0;
    end
    lfsr_stim = 16'd14818;
    lfsr_rdy = 16'd14818;
    stall_en = 1'b0;
    stall_model = 0;
    delivered_total = 0;
    cycles = 0;
    checks = 0;
    errors = 0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check("output valids after reset", out_valid, '0);
    check("input readies after reset", in_ready, '0);
    check("status word 0 after reset", csr_ro[0], '0);
    @(posedge clk);
    #2;
    check("CSR ready after reset", csr_ready, 1'b1);

    // Every opcode on every lane, accumulate off
    for (int r = 0; r < 8; r++) begin
      build_cfg(r, 1'b0, 1'b0, w);
      run_case(w, OpBeats, r[0]);
    end

    // Running sums, second start restarts them
    build_cfg(0, 1'b1, 1'b0, w);
    run_case(w, AccBeats, 1'b0);
    run_case(w, AccBeats, 1'b1);

    stall_en = 1'b1;
    build_cfg(0, 1'b0, 1'b1, w);
    run_case(w, StressBeats, 1'b1);
    stall_en = 1'b0;

    // Empty run
    run_case(w, 0, 1'b0);
    repeat (4) @(posedge clk);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
cgra_pkg.sv
cgra_cfg_if.sv
cgra_pe.sv
cgra_out_fifo.sv
cgra_array.sv
cgra_csr.sv
cgra_shell_wrapper.sv
tb_cgra_shell.sv

//--- Bender.yml
package:
  name: cgra_shell

sources:
  - cgra_pkg.sv
  - cgra_cfg_if.sv
  - cgra_pe.sv
  - cgra_out_fifo.sv
  - cgra_array.sv
  - cgra_csr.sv
  - cgra_shell_wrapper.sv
  - target: test
    files:
      - tb_cgra_shell.sv
